// ==== ahbApbBridge.f ====
src/ahbApbPkg.sv
src/ahbSlaveInterface.sv
src/apbFsmController.sv
src/ahbApbBridge.sv
dv/apbSlaveModel.sv
dv/ahbApbBridgeTb.sv

// ==== Bender.yml ====
package:
  name: ahb_apb_bridge

sources:
  - files:
      - src/ahbApbPkg.sv
      - src/ahbSlaveInterface.sv
      - src/apbFsmController.sv
      - src/ahbApbBridge.sv
  - target: test
    files:
      - dv/apbSlaveModel.sv
      - dv/ahbApbBridgeTb.sv

// ==== dv/ahbApbBridgeTb.sv ====
/* Bridge testbench: AHB master tasks, reference memory and select model,
   APB phase checker and directed plus random traffic */
`timescale 1ns/100ps
`default_nettype none

module ahbApbBridgeTb;
	import ahbApbPkg::*;

	localparam int clkPeriod = 40;
	localparam int driveDelay = 2;
	localparam int readyTimeout = 20;
	localparam int regDepth = 16;
	localparam int randomCount = 200;

	// One accepted AHB transfer as the APB side should see it
	typedef struct packed {
		logic [dataWidth-1:0] addr;
		logic write;
		logic [dataWidth-1:0] data;
	} xferT;

	logic Hclk;
	logic Hresetn;
	logic [dataWidth-1:0] Haddr;
	logic [1:0] Htrans;
	logic Hwrite;
	logic [dataWidth-1:0] Hwdata;
	logic Hselapb;
	logic [dataWidth-1:0] Prdata;
	logic [dataWidth-1:0] Hrdata;
	logic Hreadyout;
	logic [1:0] Hresp;
	apbReqT apbReq;
	apbReqT setupReq;
	logic setupPrev;
	logic pendRead;
	logic [dataWidth-1:0] pendExp;
	logic [dataWidth-1:0] refMem [numSlaves*regDepth];
	xferT expQ[$];
	xferT expXfer;
	integer seed;
	int errorCount;
	int timeoutCount;
	int setupCount;
	int stallCount;

	ahbApbBridge dut_i (.*);

	apbSlaveModel #(.regDepth(regDepth)) slave_i (.*);

	always #(clkPeriod / 2) Hclk = ~Hclk;

	// Expected one-hot select, each region slaveSpan bytes long
	function automatic logic [numSlaves-1:0] expSel(input logic [dataWidth-1:0] addr);
		logic [numSlaves-1:0] sel;
		logic [dataWidth-1:0] lo;
		sel = '0;
		for (int k = 0; k < numSlaves; k++)
		begin
			lo = slaveBase + k * slaveSpan;
			if (addr >= lo && addr - lo < slaveSpan)
				sel[k] = 1'b1;
		end
		return sel;
	endfunction

	// Reference memory slot: region first, then word
	function automatic int refIndex(input logic [dataWidth-1:0] addr);
		logic [dataWidth-1:0] offset;
		offset = addr - slaveBase;
		return (offset / slaveSpan) * regDepth + ((offset % slaveSpan) / 4) % regDepth;
	endfunction

	// Last word written, zero if never written
	function automatic logic [dataWidth-1:0] refRead(input logic [dataWidth-1:0] addr);
		return refMem[refIndex(addr)];
	endfunction

	function automatic logic [dataWidth-1:0] slotAddr(input int region, input int word);
		return slaveBase + region * slaveSpan + word * 4;
	endfunction

	task automatic compareValue(input string name, input logic [dataWidth-1:0] expV,
		input logic [dataWidth-1:0] got);
		if (got !== expV)
		begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, expV, got);
			errorCount++;
		end
	endtask

	task automatic finishRun();
		$display("Errors: %0d, timeouts: %0d, APB setup phases: %0d",
			errorCount, timeoutCount, setupCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	// One address phase; the previous data phase completes on the same edge
	task automatic busTransfer(input logic [1:0] trans, input logic selApb,
		input logic [dataWidth-1:0] addr, input logic write, input logic [dataWidth-1:0] data);
		int waitCount;
		logic taken;
		waitCount = 0;
		taken = selApb && (trans == htransNonseq || trans == htransSeq) && expSel(addr) != '0;
		Htrans = trans;
		Hselapb = selApb;
		Haddr = addr;
		Hwrite = write;
		@(negedge Hclk);
		while (!Hreadyout && waitCount < readyTimeout)
		begin
			waitCount++;
			stallCount++;
			@(negedge Hclk);
		end
		if (!Hreadyout)
		begin
			$display("Timeout at %0t: Hreadyout stayed low for %0d cycles", $time, readyTimeout);
			timeoutCount++;
			finishRun();
		end
		else
		begin
			if (pendRead)
				compareValue("Hrdata", pendExp, Hrdata);
			// Every completed data phase answers OKAY
			compareValue("Hresp", 2'b00, Hresp);
			@(posedge Hclk);
			#driveDelay;
			pendRead = taken && !write;
			Hwdata = write ? data : '0;
			if (taken && write)
				refMem[refIndex(addr)] = data;
			else if (taken)
				pendExp = refRead(addr);
			if (taken)
				expQ.push_back({addr, write, data});
		end
	endtask

	// Idle phases until all accepted transfers have left the bridge
	task automatic drainBus();
		repeat (3)
			busTransfer(htransIdle, 1'b0, '0, 1'b0, '0);
	endtask

	// APB checker, each access must follow a matching setup phase
	always @(negedge Hclk)
	begin
		if (Hresetn && apbReq.sel != '0 && !apbReq.enable)
		begin
			setupCount++;
			setupReq = apbReq;
		end
		else if (Hresetn && apbReq.sel != '0)
		begin
			if (!setupPrev || setupReq.sel != apbReq.sel || setupReq.addr != apbReq.addr
				|| setupReq.write != apbReq.write)
			begin
				$display("Access phase at %0t has no matching setup phase", $time);
				errorCount++;
			end
			if (expQ.size() == 0)
			begin
				$display("Unexpected APB access at %0t with no transfer pending", $time);
				errorCount++;
			end
			else
			begin
				expXfer = expQ.pop_front();
				compareValue("Psel", expSel(expXfer.addr), apbReq.sel);
				compareValue("Paddr", expXfer.addr, apbReq.addr);
				compareValue("Pwrite", expXfer.write, apbReq.write);
				if (expXfer.write)
					compareValue("Pwdata", expXfer.data, apbReq.wdata);
			end
		end
		setupPrev = Hresetn && apbReq.sel != '0 && !apbReq.enable;
	end

	initial
	begin
		int region;
		int word;
		int stallsBefore;
		int setupsBefore;
		logic rndWrite;
		logic [dataWidth-1:0] rndData;
		seed = 32'h2833;
		Hclk = 1'b0;
		Hresetn = 1'b0;
		Haddr = '0;
		Htrans = htransIdle;
		Hwrite = 1'b0;
		Hwdata = '0;
		Hselapb = 1'b0;
		pendRead = 1'b0;
		pendExp = '0;
		setupPrev = 1'b0;
		errorCount = 0;
		timeoutCount = 0;
		setupCount = 0;
		stallCount = 0;
		for (int i = 0; i < numSlaves * regDepth; i++)
			refMem[i] = '0;
		repeat (5) @(posedge Hclk);
		#driveDelay;
		Hresetn = 1'b1;

		// Reset values before any transfer
		@(negedge Hclk);
		compareValue("Psel", '0, apbReq.sel);
		compareValue("Penable", '0, apbReq.enable);
		compareValue("Pwrite", '0, apbReq.write);
		compareValue("Hreadyout", 1, Hreadyout);
		@(posedge Hclk);
		#driveDelay;

		// Single write and read back per peripheral
		for (int k = 0; k < numSlaves; k++)
		begin
			busTransfer(htransNonseq, 1'b1, slotAddr(k, k + 1), 1'b1, 32'hA000_0000 + k);
			drainBus();
			busTransfer(htransNonseq, 1'b1, slotAddr(k, k + 1), 1'b0, '0);
			drainBus();
		end

		// Back-to-back burst of four writes, then read back
		for (int i = 0; i < 4; i++)
			busTransfer(i == 0 ? htransNonseq : htransSeq, 1'b1, slotAddr(1, 8 + i), 1'b1,
				32'hB0B0_0000 + i);
		for (int i = 0; i < 4; i++)
			busTransfer(htransNonseq, 1'b1, slotAddr(1, 8 + i), 1'b0, '0);
		drainBus();

		// Reads directly behind writes
		busTransfer(htransNonseq, 1'b1, slotAddr(0, 3), 1'b1, 32'hC3C3_0003);
		busTransfer(htransNonseq, 1'b1, slotAddr(0, 3), 1'b0, '0);
		busTransfer(htransNonseq, 1'b1, slotAddr(2, 5), 1'b1, 32'hC5C5_0005);
		busTransfer(htransNonseq, 1'b1, slotAddr(2, 5), 1'b0, '0);
		busTransfer(htransNonseq, 1'b1, slotAddr(1, 9), 1'b0, '0);
		busTransfer(htransNonseq, 1'b1, slotAddr(1, 9), 1'b1, 32'hC9C9_0009);
		busTransfer(htransNonseq, 1'b1, slotAddr(0, 1), 1'b0, '0);
		drainBus();

		// Transfers the bridge must ignore
		stallsBefore = stallCount;
		setupsBefore = setupCount;
		busTransfer(htransIdle, 1'b1, slotAddr(0, 2), 1'b1, 32'h1111_1111);
		busTransfer(htransBusy, 1'b1, slotAddr(1, 2), 1'b0, '0);
		busTransfer(htransNonseq, 1'b0, slotAddr(2, 2), 1'b1, 32'h2222_2222);
		busTransfer(htransNonseq, 1'b1, slaveBase - 4, 1'b1, 32'h3333_3333);
		busTransfer(htransSeq, 1'b1, slaveBase + numSlaves * slaveSpan, 1'b0, '0);
		drainBus();
		if (setupCount != setupsBefore || stallCount != stallsBefore)
		begin
			$display("Ignored transfers caused APB activity or wait states");
			errorCount++;
		end

		// Random traffic with idle gaps
		for (int i = 0; i < randomCount; i++)
		begin
			region = $unsigned($random(seed)) % numSlaves;
			word = $unsigned($random(seed)) % regDepth;
			rndWrite = $random(seed) & 1;
			rndData = $random(seed);
			busTransfer(htransNonseq, 1'b1, slotAddr(region, word), rndWrite, rndData);
			repeat ($unsigned($random(seed)) % 3)
				busTransfer(htransIdle, 1'b0, '0, 1'b0, '0);
		end
		drainBus();

		if (expQ.size() != 0)
		begin
			$display("%0d accepted transfers never reached the APB", expQ.size());
			errorCount++;
		end
		finishRun();
	end

endmodule

`default_nettype wire

// ==== dv/apbSlaveModel.sv ====
/* Zero-wait APB register banks, one bank per peripheral select */
`timescale 1ns/100ps
`default_nettype none

module apbSlaveModel #(
	parameter int regDepth = 16
) (
	input  logic Hclk,
	input  logic Hresetn,
	input  ahbApbPkg::apbReqT apbReq,
	output logic [ahbApbPkg::dataWidth-1:0] Prdata
);
	import ahbApbPkg::*;

	localparam int idxBits = $clog2(regDepth);

	logic [dataWidth-1:0] regBank [numSlaves][regDepth];
	logic [idxBits-1:0] wordIdx;

	// Word select from the byte address
	assign wordIdx = apbReq.addr[idxBits+1:2];

	// Writes land at the end of the access phase
	always_ff @(posedge Hclk)
	begin
		for (int k = 0; k < numSlaves; k++)
		begin
			for (int w = 0; w < regDepth; w++)
			begin
				if (!Hresetn)
					regBank[k][w] <= '0;
				else if (apbReq.sel[k] && apbReq.enable && apbReq.write && wordIdx == w)
					regBank[k][w] <= apbReq.wdata;
			end
		end
	end

	// Read data only during a read access phase
	always_comb
	begin
		Prdata = '0;
		for (int k = 0; k < numSlaves; k++)
		begin
			if (apbReq.sel[k] && apbReq.enable && !apbReq.write)
				Prdata = regBank[k][wordIdx];
		end
	end

endmodule

`default_nettype wire

// ==== src/ahbApbBridge.sv ====
/* AHB-Lite to APB bridge top: slave interface plus APB controller */
`timescale 1ns/100ps
`default_nettype none

module ahbApbBridge (
	input  logic Hclk,
	input  logic Hresetn,
	input  logic [ahbApbPkg::dataWidth-1:0] Haddr,
	input  logic [1:0] Htrans,
	input  logic Hwrite,
	input  logic [ahbApbPkg::dataWidth-1:0] Hwdata,
	input  logic Hselapb,
	input  logic [ahbApbPkg::dataWidth-1:0] Prdata,
	output logic [ahbApbPkg::dataWidth-1:0] Hrdata,
	output logic Hreadyout,
	output logic [1:0] Hresp,
	output ahbApbPkg::apbReqT apbReq
);
	import ahbApbPkg::*;

	logic valid;
	logic writeReg;
	logic [dataWidth-1:0] wdataReg;
	ahbReqT curReq;
	ahbReqT prevReq;
	ahbReqT pipeReq;

	// Read data straight from the selected peripheral
	assign Hrdata = Prdata;
	// Always OKAY
	assign Hresp = 2'b00;

	ahbSlaveInterface ahbSlave_i (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hreadyin(Hreadyout),
		.Hselapb(Hselapb),
		.Hwdata(Hwdata),
		.valid(valid),
		.curReq(curReq),
		.prevReq(prevReq),
		.pipeReq(pipeReq),
		.writeReg(writeReg),
		.wdataReg(wdataReg)
	);

	apbFsmController apbCtrl_i (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.valid(valid),
		.Hwrite(Hwrite),
		.writeReg(writeReg),
		.curReq(curReq),
		.prevReq(prevReq),
		.pipeReq(pipeReq),
		.Hwdata(Hwdata),
		.wdataReg(wdataReg),
		.apbReq(apbReq),
		.Hreadyout(Hreadyout)
	);

endmodule

`default_nettype wire

// ==== src/apbFsmController.sv ====
/* APB sequencer: eight-state FSM with registered APB outputs and
   Hreadyout, driving setup and access phases per AHB transfer */
`timescale 1ns/100ps
`default_nettype none

module apbFsmController (
	input  logic Hclk,
	input  logic Hresetn,
	input  logic valid,
	input  logic Hwrite,
	input  logic writeReg,
	input  ahbApbPkg::ahbReqT curReq,
	input  ahbApbPkg::ahbReqT prevReq,
	input  ahbApbPkg::ahbReqT pipeReq,
	input  logic [ahbApbPkg::dataWidth-1:0] Hwdata,
	input  logic [ahbApbPkg::dataWidth-1:0] wdataReg,
	output ahbApbPkg::apbReqT apbReq,
	output logic Hreadyout
);
	import ahbApbPkg::*;

	typedef enum logic [2:0] {
		stIdle = 3'b000,
		stWwait = 3'b001,
		stRead = 3'b010,
		stWrite = 3'b011,
		stWriteP = 3'b100,
		stRenable = 3'b101,
		stWenable = 3'b110,
		stWenableP = 3'b111
	} stateT;

	stateT state;
	stateT nextState;
	apbReqT nextReq;
	logic nextReady;

	// Builds an APB setup phase from a captured address phase
	function automatic apbReqT setupPhase(
		input ahbReqT req,
		input logic [dataWidth-1:0] wdata
	);
		apbReqT phase;
		phase.sel = req.sel;
		phase.enable = 1'b0;
		phase.write = req.write;
		phase.addr = req.addr;
		phase.wdata = wdata;
		return phase;
	endfunction

	// Next state
	always_comb
	begin
		nextState = state;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				if (!valid)
					nextState = stIdle;
				else if (Hwrite)
					nextState = stWwait;
				else
					nextState = stRead;
			end
			stWwait:
				nextState = valid ? stWriteP : stWrite;
			stRead:
				nextState = stRenable;
			stWrite:
				nextState = valid ? stWenableP : stWenable;
			stWriteP:
				nextState = stWenableP;
			stWenableP:
			begin
				if (!writeReg)
					nextState = stRead;
				else if (valid)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end
			default:
				nextState = stIdle;
		endcase
	end

	// Next outputs; payload holds unless a setup phase is issued
	always_comb
	begin
		nextReq = apbReq;
		nextReq.sel = '0;
		nextReq.enable = 1'b0;
		nextReady = 1'b1;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				// Reads go out at once, writes wait for their data
				if (valid && !Hwrite)
				begin
					nextReq = setupPhase(curReq, apbReq.wdata);
					nextReady = 1'b0;
				end
			end
			stWwait:
			begin
				nextReq = setupPhase(prevReq, Hwdata);
				nextReady = 1'b0;
			end
			stRead, stWrite:
			begin
				nextReq.sel = apbReq.sel;
				nextReq.enable = 1'b1;
			end
			stWriteP:
			begin
				nextReq.sel = apbReq.sel;
				nextReq.enable = 1'b1;
				// Pending read keeps the bus stalled until its own access phase
				nextReady = writeReg;
			end
			stWenableP:
			begin
				// Registered data for a write, bus data unchanged for a read
				nextReq = setupPhase(pipeReq, writeReg ? wdataReg : apbReq.wdata);
				nextReady = 1'b0;
			end
			default:
			begin
				nextReady = 1'b1;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= stIdle;
		else
			state <= nextState;
	end

	// Output stage, one edge behind the state decision
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			apbReq.sel <= '0;
			apbReq.enable <= 1'b0;
			apbReq.write <= 1'b0;
			Hreadyout <= 1'b1;
		end
		else
		begin
			apbReq <= nextReq;
			Hreadyout <= nextReady;
		end
	end

endmodule

`default_nettype wire

// ==== src/ahbSlaveInterface.sv ====
/* AHB slave side of the bridge: transfer qualification, peripheral decode,
   two-deep address phase history and registered write data */
`timescale 1ns/100ps
`default_nettype none

module ahbSlaveInterface (
	input  logic Hclk,
	input  logic Hresetn,
	input  logic [ahbApbPkg::dataWidth-1:0] Haddr,
	input  logic [1:0] Htrans,
	input  logic Hwrite,
	input  logic Hreadyin,
	input  logic Hselapb,
	input  logic [ahbApbPkg::dataWidth-1:0] Hwdata,
	output logic valid,
	output ahbApbPkg::ahbReqT curReq,
	output ahbApbPkg::ahbReqT prevReq,
	output ahbApbPkg::ahbReqT pipeReq,
	output logic writeReg,
	output logic [ahbApbPkg::dataWidth-1:0] wdataReg
);
	import ahbApbPkg::*;

	logic [dataWidth-1:0] offset;
	logic [dataWidth-1:0] regionIdx;
	logic inWindow;
	logic activeTrans;

	// Window check and region decode
	always_comb
	begin
		offset = Haddr - slaveBase;
		inWindow = (Haddr >= slaveBase) && (offset < numSlaves * slaveSpan);
		regionIdx = offset / slaveSpan;
		curReq.addr = Haddr;
		curReq.write = Hwrite;
		for (int k = 0; k < numSlaves; k++)
		begin
			curReq.sel[k] = inWindow && (regionIdx == k);
		end
	end

	// Only NONSEQ and SEQ carry a transfer
	assign activeTrans = (Htrans == htransNonseq) || (Htrans == htransSeq);
	assign valid = Hselapb && Hreadyin && activeTrans && inWindow;

	// Address history, sampled every cycle
	// A held address phase lands in pipeReq for the pipelined write path
	always_ff @(posedge Hclk)
	begin
		prevReq <= curReq;
		pipeReq <= prevReq;
		wdataReg <= Hwdata;
	end

	// Direction of the last accepted transfer
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			writeReg <= 1'b0;
		end
		else if (valid)
		begin
			writeReg <= Hwrite;
		end
	end

endmodule

`default_nettype wire

// ==== src/ahbApbPkg.sv ====
/* Shared AHB-to-APB bridge definitions: address map, AHB transfer types
   and the packed request structs for both bus sides */
`default_nettype none

package ahbApbPkg;

	// Bus widths and peripheral count
	localparam int dataWidth = 32;
	localparam int numSlaves = 3;

	// Bridge window, one region per peripheral
	localparam logic [dataWidth-1:0] slaveBase = 32'h8000_0000;
	localparam logic [dataWidth-1:0] slaveSpan = 32'h0400_0000;

	// AHB Htrans codes
	localparam logic [1:0] htransIdle = 2'b00;
	localparam logic [1:0] htransBusy = 2'b01;
	localparam logic [1:0] htransNonseq = 2'b10;
	localparam logic [1:0] htransSeq = 2'b11;

	// One captured AHB address phase
	typedef struct packed {
		logic [dataWidth-1:0] addr;
		logic write;
		logic [numSlaves-1:0] sel;
	} ahbReqT;

	// Registered APB outputs
	typedef struct packed {
		logic [numSlaves-1:0] sel;
		logic enable;
		logic write;
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
	} apbReqT;

endpackage

`default_nettype wire
